// File: build.f
hw/dcache_cfg_pkg.sv
hw/dcache_bus_pkg.sv
hw/dcache_way.sv
hw/dcache_lru.sv
hw/dcache_hit_select.sv
hw/dcache_ctrl.sv
hw/dcache_top.sv
testbench/dcache_checker.sv
testbench/tb_dcache.sv

// File: hw/dcache_bus_pkg.sv
package dcache_bus_pkg;
  import dcache_cfg_pkg::*;

  //////////////////////////////
  // CPU side
  //////////////////////////////

  // Request kinds, invalidate works on one set
  typedef enum logic [1:0] {
    OP_READ,
    OP_WRITE,
    OP_INVAL
  } cpu_op_e;

  typedef struct packed {
    cpu_op_e op;
    addr_t   addr;
    bsel_t   bsel;
    word_t   wdata;
  } cpu_req_t;

  // rdata only meaningful for reads
  typedef struct packed {
    logic  hit;
    word_t rdata;
  } cpu_rsp_t;

  //////////////////////////////
  // Memory side
  //////////////////////////////

  // Block aligned, offset bits zero
  typedef struct packed {
    addr_t block_addr;
  } refill_req_t;

  typedef word_t mem_word_t;

  //////////////////////////////
  // Way ports
  //////////////////////////////

  // Broadcast to all ways
  typedef struct packed {
    set_idx_t  set_idx;
    word_sel_t wsel;
    tag_t      tag;
    logic      strobe;
  } way_lookup_t;

  // Write command, enables carry one bit per way
  typedef struct packed {
    set_idx_t  set_idx;
    word_sel_t wsel;
    word_t     data;
    way_vec_t  data_we;
    way_vec_t  tag_we;
    tag_t      tag;
    logic      valid;
    logic      inval_set;
  } way_write_t;

  typedef struct packed {
    logic  hit;
    word_t data;
  } way_result_t;

  // Controller states
  typedef enum logic [2:0] {
    S_IDLE,
    S_LOOKUP,
    S_DECIDE,
    S_REFILL,
    S_FILL_DONE
  } ctrl_state_e;

endpackage

// File: hw/dcache_cfg_pkg.sv
package dcache_cfg_pkg;

  //////////////////////////////
  // Cache geometry
  //////////////////////////////

  // Byte address width seen by the core
  localparam int ADDR_W          = 32;
  // Associativity and number of sets
  localparam int WAYS            = 4;
  localparam int SETS            = 16;
  // Block of four 32-bit words, 16 bytes
  localparam int WORDS_PER_BLOCK = 4;
  localparam int OFFSET_W        = 4;
  localparam int SET_W           = 4;
  localparam int WORD_SEL_W      = 2;
  // Tag is whatever lies above set and offset
  localparam int TAG_W           = ADDR_W - SET_W - OFFSET_W;
  // One bit per pair of ways
  localparam int AGE_W           = WAYS * (WAYS - 1) / 2;

  // Age order after reset: way 0 oldest, way 3 newest
  // Every pair (i, j) with i < j says j was accessed later
  localparam logic [AGE_W-1:0] AGE_RESET = '1;

  //////////////////////////////
  // Width types
  //////////////////////////////

  typedef logic [ADDR_W-1:0]        addr_t;
  typedef logic [31:0]              word_t;
  typedef logic [3:0]               bsel_t;
  typedef logic [TAG_W-1:0]         tag_t;
  typedef logic [SET_W-1:0]         set_idx_t;
  typedef logic [WORD_SEL_W-1:0]    word_sel_t;
  // One bit per way
  typedef logic [WAYS-1:0]          way_vec_t;
  typedef logic [$clog2(WAYS)-1:0]  way_idx_t;
  typedef logic [AGE_W-1:0]         age_t;

endpackage

// File: hw/dcache_ctrl.sv
`timescale 1ns/1ps

module dcache_ctrl
  import dcache_cfg_pkg::*;
  import dcache_bus_pkg::*;
(
  input  logic        clk,
  input  logic        rst,
  // CPU side
  input  logic        cpu_req_valid_i,
  input  cpu_req_t    cpu_req_i,
  output logic        cpu_ack_o,
  output cpu_rsp_t    cpu_rsp_o,
  // Memory side
  output logic        refill_req_valid_o,
  output refill_req_t refill_req_o,
  input  logic        mem_valid_i,
  input  mem_word_t   mem_i,
  // Hit selector
  input  logic        hit_i,
  input  way_idx_t    hit_way_i,
  input  word_t       hit_data_i,
  // LRU
  input  way_vec_t    victim_i,
  // Ways
  output way_lookup_t lookup_o,
  output way_write_t  write_o,
  output logic        lru_access_o,
  output way_idx_t    lru_way_o,
  output logic        lru_reset_o,
  output set_idx_t    lru_set_o
);

  ctrl_state_e state_q;
  cpu_req_t    req_q;
  // Refill bookkeeping
  way_vec_t    victim_q;
  way_idx_t    victim_idx;
  word_sel_t   fill_cnt_q;
  word_t       fill_word_q;

  // Request fields
  tag_t      req_tag;
  set_idx_t  req_set;
  word_sel_t req_wsel;
  logic      is_read;
  logic      is_write;
  logic      is_inval;
  logic      decide;
  logic      refill_start;
  logic      fill_last;
  word_t     merged;

  assign req_tag  = req_q.addr[ADDR_W-1 -: TAG_W];
  assign req_set  = req_q.addr[OFFSET_W +: SET_W];
  assign req_wsel = req_q.addr[OFFSET_W-WORD_SEL_W +: WORD_SEL_W];
  assign is_read  = (req_q.op == OP_READ);
  assign is_write = (req_q.op == OP_WRITE);
  assign is_inval = (req_q.op == OP_INVAL);

  assign decide       = (state_q == S_DECIDE);
  assign refill_start = decide && is_read && !hit_i;
  assign fill_last    = mem_valid_i && (fill_cnt_q == word_sel_t'(WORDS_PER_BLOCK - 1));

  //////////////////////////////
  // State machine
  //////////////////////////////

  always_ff @(posedge clk) begin
    if (rst) begin
      state_q    <= S_IDLE;
      fill_cnt_q <= '0;
    end else begin
      case (state_q)
        S_IDLE: begin
          if (cpu_req_valid_i) begin
            state_q <= S_LOOKUP;
          end
        end
        // Ways read their arrays here
        S_LOOKUP: state_q <= S_DECIDE;
        S_DECIDE: begin
          if (refill_start) begin
            state_q    <= S_REFILL;
            fill_cnt_q <= '0;
          end else begin
            state_q <= S_IDLE;
          end
        end
        S_REFILL: begin
          if (mem_valid_i) begin
            fill_cnt_q <= fill_cnt_q + 1'b1;
          end
          if (fill_last) begin
            state_q <= S_FILL_DONE;
          end
        end
        S_FILL_DONE: state_q <= S_IDLE;
        default:     state_q <= S_IDLE;
      endcase
    end
  end

  // Request held until the next strobe
  always_ff @(posedge clk) begin
    if (rst) begin
      req_q <= '0;
    end else if (cpu_req_valid_i) begin
      req_q <= cpu_req_i;
    end
  end

  // Victim and requested refill word
  always_ff @(posedge clk) begin
    if (refill_start) begin
      victim_q <= victim_i;
    end
    if (state_q == S_REFILL && mem_valid_i && fill_cnt_q == req_wsel) begin
      fill_word_q <= mem_i;
    end
  end

  always_comb begin
    victim_idx = '0;
    for (int w = 0; w < WAYS; w++) begin
      if (victim_q[w]) begin
        victim_idx = way_idx_t'(w);
      end
    end
  end

  // Enabled bytes over the stored word
  always_comb begin
    merged = hit_data_i;
    for (int b = 0; b < 4; b++) begin
      if (req_q.bsel[b]) begin
        merged[8*b +: 8] = req_q.wdata[8*b +: 8];
      end
    end
  end

  //////////////////////////////
  // Way and LRU commands
  //////////////////////////////

  assign lookup_o.set_idx = req_set;
  assign lookup_o.wsel    = req_wsel;
  assign lookup_o.tag     = req_tag;
  assign lookup_o.strobe  = (state_q == S_LOOKUP);

  always_comb begin
    write_o.set_idx   = req_set;
    write_o.wsel      = req_wsel;
    write_o.data      = merged;
    write_o.data_we   = '0;
    write_o.tag_we    = '0;
    write_o.tag       = req_tag;
    write_o.valid     = 1'b1;
    write_o.inval_set = 1'b0;
    case (state_q)
      S_DECIDE: begin
        if (is_write && hit_i) begin
          write_o.data_we = way_vec_t'(1) << hit_way_i;
        end
        write_o.inval_set = is_inval;
      end
      // Words arrive in order 0 to 3
      S_REFILL: begin
        write_o.wsel = fill_cnt_q;
        write_o.data = mem_i;
        if (mem_valid_i) begin
          write_o.data_we = victim_q;
        end
      end
      S_FILL_DONE: write_o.tag_we = victim_q;
      default: ;
    endcase
  end

  assign lru_set_o    = req_set;
  assign lru_access_o = (decide && hit_i && !is_inval) || (state_q == S_FILL_DONE);
  assign lru_way_o    = (state_q == S_FILL_DONE) ? victim_idx : hit_way_i;
  assign lru_reset_o  = decide && is_inval;

  //////////////////////////////
  // CPU and memory outputs
  //////////////////////////////

  // Read misses answer after the refill instead
  assign cpu_ack_o       = (decide && !refill_start) || (state_q == S_FILL_DONE);
  assign cpu_rsp_o.hit   = decide && hit_i;
  assign cpu_rsp_o.rdata = (state_q == S_FILL_DONE) ? fill_word_q : hit_data_i;

  assign refill_req_valid_o      = refill_start;
  assign refill_req_o.block_addr = {req_q.addr[ADDR_W-1:OFFSET_W], {OFFSET_W{1'b0}}};

  // One outstanding request
  a_req_in_idle: assert property (@(posedge clk) disable iff (rst)
    cpu_req_valid_i |-> state_q == S_IDLE)
    else $error("Request strobe while busy");

  // Memory only answers a pending refill
  a_mem_in_refill: assert property (@(posedge clk) disable iff (rst)
    mem_valid_i |-> state_q == S_REFILL)
    else $error("Refill word outside refill");

endmodule

// File: hw/dcache_hit_select.sv
`timescale 1ns/1ps

module dcache_hit_select
  import dcache_cfg_pkg::*;
  import dcache_bus_pkg::*;
(
  input  way_result_t results_i [WAYS],
  output logic        hit_o,
  output way_idx_t    hit_way_o,
  output word_t       hit_data_o
);

  way_vec_t hit_vec;

  // Gather hit bits and encode the hitting way
  always_comb begin
    hit_way_o = '0;
    for (int w = 0; w < WAYS; w++) begin
      hit_vec[w] = results_i[w].hit;
      if (results_i[w].hit) begin
        hit_way_o = way_idx_t'(w);
      end
    end
  end

  assign hit_o = |hit_vec;

  // Word of the hitting way, way 0 when nothing hits
  assign hit_data_o = results_i[hit_way_o].data;

  //////////////////////////////
  // Checks
  //////////////////////////////

  // Refill only fills a way after a miss, so a tag lives in one way
  always_comb begin
    a_hit_onehot0: assert #0 ($onehot0(hit_vec))
      else $error("Several ways hit: %b", hit_vec);
  end

endmodule

// File: hw/dcache_lru.sv
`timescale 1ns/1ps

module dcache_lru
  import dcache_cfg_pkg::*;
(
  input  logic     clk,
  input  logic     rst,
  input  set_idx_t set_i,
  input  logic     access_i,
  input  way_idx_t access_way_i,
  input  logic     reset_set_i,
  output way_vec_t victim_o
);

  // Pair bit set means the higher way was accessed later
  // Pair order (0,1) (0,2) (0,3) (1,2) (1,3) (2,3)
  age_t hist_q [SETS];
  age_t cur_hist;
  age_t next_hist;

  assign cur_hist = hist_q[set_i];

  // Victim is older than every other way
  always_comb begin
    int p;
    victim_o = '1;
    p = 0;
    for (int i = 0; i < WAYS; i++) begin
      for (int j = i + 1; j < WAYS; j++) begin
        // The newer way of each pair drops out
        if (cur_hist[p]) begin
          victim_o[j] = 1'b0;
        end else begin
          victim_o[i] = 1'b0;
        end
        p++;
      end
    end
  end

  // Accessed way becomes newer than all others
  always_comb begin
    int p;
    next_hist = cur_hist;
    p = 0;
    for (int i = 0; i < WAYS; i++) begin
      for (int j = i + 1; j < WAYS; j++) begin
        if (access_way_i == way_idx_t'(j)) begin
          next_hist[p] = 1'b1;
        end else if (access_way_i == way_idx_t'(i)) begin
          next_hist[p] = 1'b0;
        end
        p++;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int s = 0; s < SETS; s++) begin
        hist_q[s] <= AGE_RESET;
      end
    end else if (reset_set_i) begin
      // Invalidated set starts over from way 0
      hist_q[set_i] <= AGE_RESET;
    end else if (access_i) begin
      hist_q[set_i] <= next_hist;
    end
  end

  // History stays a total order across all updates
  a_victim_onehot: assert property (@(posedge clk) disable iff (rst) $onehot(victim_o))
    else $error("LRU victim not one-hot: %b", victim_o);

endmodule

// File: hw/dcache_top.sv
`timescale 1ns/1ps

module dcache_top
  import dcache_cfg_pkg::*;
  import dcache_bus_pkg::*;
(
  input  logic        clk,
  input  logic        rst,
  // CPU side
  input  logic        cpu_req_valid_i,
  input  cpu_req_t    cpu_req_i,
  output logic        cpu_ack_o,
  output cpu_rsp_t    cpu_rsp_o,
  // Memory side
  output logic        refill_req_valid_o,
  output refill_req_t refill_req_o,
  input  logic        mem_valid_i,
  input  mem_word_t   mem_i
);

  way_lookup_t lookup;
  way_write_t  write_cmd;
  way_result_t results [WAYS];

  logic     hit;
  way_idx_t hit_way;
  word_t    hit_data;
  way_vec_t victim;

  logic     lru_access;
  way_idx_t lru_way;
  logic     lru_reset;
  set_idx_t lru_set;

  dcache_ctrl u_ctrl (
    .clk                (clk),
    .rst                (rst),
    .cpu_req_valid_i    (cpu_req_valid_i),
    .cpu_req_i          (cpu_req_i),
    .cpu_ack_o          (cpu_ack_o),
    .cpu_rsp_o          (cpu_rsp_o),
    .refill_req_valid_o (refill_req_valid_o),
    .refill_req_o       (refill_req_o),
    .mem_valid_i        (mem_valid_i),
    .mem_i              (mem_i),
    .hit_i              (hit),
    .hit_way_i          (hit_way),
    .hit_data_i         (hit_data),
    .victim_i           (victim),
    .lookup_o           (lookup),
    .write_o            (write_cmd),
    .lru_access_o       (lru_access),
    .lru_way_o          (lru_way),
    .lru_reset_o        (lru_reset),
    .lru_set_o          (lru_set)
  );

  //////////////////////////////
  // Ways
  //////////////////////////////

  for (genvar g = 0; g < WAYS; g++) begin : g_way
    localparam way_idx_t WAY_IDX = way_idx_t'(g);
    way_write_t way_wr;

    // Each way only sees its own enable bits
    always_comb begin
      way_wr         = write_cmd;
      way_wr.data_we = write_cmd.data_we & (way_vec_t'(1) << WAY_IDX);
      way_wr.tag_we  = write_cmd.tag_we & (way_vec_t'(1) << WAY_IDX);
    end

    dcache_way u_way (
      .clk      (clk),
      .rst      (rst),
      .lookup_i (lookup),
      .write_i  (way_wr),
      .result_o (results[g])
    );
  end

  dcache_lru u_lru (
    .clk          (clk),
    .rst          (rst),
    .set_i        (lru_set),
    .access_i     (lru_access),
    .access_way_i (lru_way),
    .reset_set_i  (lru_reset),
    .victim_o     (victim)
  );

  dcache_hit_select u_hit_select (
    .results_i  (results),
    .hit_o      (hit),
    .hit_way_o  (hit_way),
    .hit_data_o (hit_data)
  );

endmodule

// File: hw/dcache_way.sv
`timescale 1ns/1ps

module dcache_way
  import dcache_cfg_pkg::*;
  import dcache_bus_pkg::*;
(
  input  logic        clk,
  input  logic        rst,
  input  way_lookup_t lookup_i,
  input  way_write_t  write_i,
  output way_result_t result_o
);

  // Per-set valid bits
  logic [SETS-1:0] valid_q;
  // Tag and data storage
  tag_t  tag_mem  [SETS];
  word_t data_mem [SETS*WORDS_PER_BLOCK];

  // Registered lookup result
  logic  valid_rd_q;
  tag_t  tag_rd_q;
  word_t data_rd_q;

  // Word addresses, set in the upper bits
  logic [SET_W+WORD_SEL_W-1:0] rd_addr;
  logic [SET_W+WORD_SEL_W-1:0] wr_addr;

  assign rd_addr = {lookup_i.set_idx, lookup_i.wsel};
  assign wr_addr = {write_i.set_idx, write_i.wsel};

  // The top masks the enables, so any set bit addresses this way
  always_ff @(posedge clk) begin
    if (rst) begin
      valid_q <= '0;
    end else if (write_i.inval_set) begin
      valid_q[write_i.set_idx] <= 1'b0;
    end else if (|write_i.tag_we) begin
      valid_q[write_i.set_idx] <= write_i.valid;
    end
  end

  always_ff @(posedge clk) begin
    if (|write_i.tag_we) begin
      tag_mem[write_i.set_idx] <= write_i.tag;
    end
    // Refill words and write hit merges
    if (|write_i.data_we) begin
      data_mem[wr_addr] <= write_i.data;
    end
  end

  //////////////////////////////
  // Lookup read port
  //////////////////////////////

  always_ff @(posedge clk) begin
    if (rst) begin
      valid_rd_q <= 1'b0;
    end else if (lookup_i.strobe) begin
      valid_rd_q <= valid_q[lookup_i.set_idx];
    end
  end

  always_ff @(posedge clk) begin
    if (lookup_i.strobe) begin
      tag_rd_q  <= tag_mem[lookup_i.set_idx];
      data_rd_q <= data_mem[rd_addr];
    end
  end

  // Request tag is held by the controller, compare after the read
  assign result_o.hit  = valid_rd_q && (tag_rd_q == lookup_i.tag);
  assign result_o.data = data_rd_q;

endmodule

// File: testbench/dcache_checker.sv
`timescale 1ns/1ps

module dcache_checker
  import dcache_cfg_pkg::*;
  import dcache_bus_pkg::*;
(
  input  logic        clk,
  input  logic        rst,
  input  logic        cpu_req_valid_i,
  input  cpu_req_t    cpu_req_i,
  input  logic        cpu_ack_i,
  input  cpu_rsp_t    cpu_rsp_i,
  input  logic        refill_req_valid_i,
  input  refill_req_t refill_req_i,
  input  logic        mem_valid_i,
  output int          mismatch_cnt_o,
  output int          fault_cnt_o
);

  // Reference copy of valid bits and tags
  logic  ref_valid [SETS][WAYS];
  tag_t  ref_tag   [SETS][WAYS];
  // Rank 0 is the oldest way of a set
  int    ref_rank  [SETS][WAYS];
  // Memory image as seen through the write-through path
  word_t ref_img   [512];

  int       mismatch_cnt = 0;
  int       fault_cnt    = 0;
  int       cyc          = 0;
  logic     pending      = 1'b0;
  logic     in_refill    = 1'b0;
  cpu_req_t req;
  logic     req_hit;
  way_idx_t req_way;
  int       ack_due;
  int       refill_due;
  int       words_seen;

  assign mismatch_cnt_o = mismatch_cnt;
  assign fault_cnt_o    = fault_cnt;

  // Same fill pattern as the memory model, over the whole image index
  initial begin
    for (int i = 0; i < 512; i++) begin
      ref_img[i] = (i * 32'h9e37_79b9) ^ 32'ha5c3_0f96;
    end
  end

  task automatic note_mismatch(input string name, input logic [31:0] exp_v,
                               input logic [31:0] act_v);
    mismatch_cnt++;
    $display("MISMATCH %s expected %h actual %h", name, exp_v, act_v);
  endtask

  // Tag low bits pick the image slice, then set and word
  function automatic int img_index(input addr_t a);
    return int'(a[10:2]);
  endfunction

  function automatic logic find_way(input set_idx_t s, input tag_t t, output way_idx_t way);
    logic found;
    found = 1'b0;
    way   = '0;
    for (int w = 0; w < WAYS; w++) begin
      if (ref_valid[s][w] && ref_tag[s][w] == t) begin
        found = 1'b1;
        way   = way_idx_t'(w);
      end
    end
    return found;
  endfunction

  // Ways newer than the accessed one move down a rank
  task automatic make_newest(input set_idx_t s, input way_idx_t way);
    int old_rank;
    old_rank = ref_rank[s][way];
    for (int w = 0; w < WAYS; w++) begin
      if (ref_rank[s][w] > old_rank) begin
        ref_rank[s][w]--;
      end
    end
    ref_rank[s][way] = WAYS - 1;
  endtask

  function automatic way_idx_t oldest_way(input set_idx_t s);
    way_idx_t way;
    way = '0;
    for (int w = 0; w < WAYS; w++) begin
      if (ref_rank[s][w] == 0) begin
        way = way_idx_t'(w);
      end
    end
    return way;
  endfunction

  // Way 0 oldest up to way 3 newest
  task automatic reset_order(input set_idx_t s);
    for (int w = 0; w < WAYS; w++) begin
      ref_rank[s][w] = w;
      ref_valid[s][w] = 1'b0;
    end
  endtask

  //////////////////////////////
  // Mid-cycle compare
  //////////////////////////////

  always @(negedge clk) begin : watch
    logic     exp_ack;
    logic     exp_refill;
    set_idx_t s;
    word_t    exp_word;
    if (rst) begin
      if (cpu_ack_i !== 1'b0) begin
        note_mismatch("reset_ack", 32'd0, 32'(cpu_ack_i));
      end
      if (refill_req_valid_i !== 1'b0) begin
        note_mismatch("reset_refill_req", 32'd0, 32'(refill_req_valid_i));
      end
      for (int i = 0; i < SETS; i++) begin
        reset_order(set_idx_t'(i));
      end
      pending   = 1'b0;
      in_refill = 1'b0;
    end else begin
      cyc++;
      exp_ack    = pending && (cyc == ack_due);
      exp_refill = pending && (cyc == refill_due);
      if (cpu_ack_i !== exp_ack) begin
        note_mismatch("ack_timing", 32'(exp_ack), 32'(cpu_ack_i));
      end
      if (refill_req_valid_i !== exp_refill) begin
        note_mismatch("refill_req_timing", 32'(exp_refill), 32'(refill_req_valid_i));
      end
      // Count refill words, the last one fixes the ack cycle
      if (mem_valid_i) begin
        if (!in_refill) begin
          fault_cnt++;
          $display("Refill word arrived while no refill was pending");
        end else begin
          words_seen++;
          if (words_seen == WORDS_PER_BLOCK) begin
            in_refill = 1'b0;
            ack_due   = cyc + 1;
          end
        end
      end
      if (exp_refill) begin
        if (refill_req_i.block_addr !== {req.addr[ADDR_W-1:OFFSET_W], 4'h0}) begin
          note_mismatch("refill_addr", {req.addr[ADDR_W-1:OFFSET_W], 4'h0},
                        refill_req_i.block_addr);
        end
        in_refill  = 1'b1;
        words_seen = 0;
      end
      if (exp_ack) begin
        s = req.addr[OFFSET_W +: SET_W];
        case (req.op)
          OP_READ: begin
            exp_word = ref_img[img_index(req.addr)];
            if (cpu_ack_i && cpu_rsp_i.hit !== req_hit) begin
              note_mismatch("read_hit_flag", 32'(req_hit), 32'(cpu_rsp_i.hit));
            end
            if (cpu_ack_i && cpu_rsp_i.rdata !== exp_word) begin
              note_mismatch(req_hit ? "read_hit_data" : "read_miss_data", exp_word,
                            cpu_rsp_i.rdata);
            end
            // Miss fills the oldest way
            if (!req_hit) begin
              req_way              = oldest_way(s);
              ref_valid[s][req_way] = 1'b1;
              ref_tag[s][req_way]   = req.addr[ADDR_W-1 -: TAG_W];
            end
            make_newest(s, req_way);
          end
          OP_WRITE: begin
            if (cpu_ack_i && cpu_rsp_i.hit !== req_hit) begin
              note_mismatch("write_hit_flag", 32'(req_hit), 32'(cpu_rsp_i.hit));
            end
            if (req_hit) begin
              make_newest(s, req_way);
            end
          end
          default: reset_order(s);
        endcase
        pending = 1'b0;
      end
      if (cpu_req_valid_i) begin
        if (pending) begin
          fault_cnt++;
          $display("New request strobed while the previous one was still pending");
        end
        req        = cpu_req_i;
        pending    = 1'b1;
        req_hit    = find_way(req.addr[OFFSET_W +: SET_W], req.addr[ADDR_W-1 -: TAG_W],
                              req_way);
        ack_due    = -1;
        refill_due = -1;
        if (req.op == OP_READ && !req_hit) begin
          refill_due = cyc + 2;
        end else begin
          ack_due = cyc + 2;
        end
        // Write-through reaches memory whether or not it hits
        if (req.op == OP_WRITE) begin
          for (int b = 0; b < 4; b++) begin
            if (req.bsel[b]) begin
              ref_img[img_index(req.addr)][8*b +: 8] = req.wdata[8*b +: 8];
            end
          end
        end
      end
    end
  end

endmodule

// File: testbench/tb_dcache.sv
`timescale 1ns/1ps

module tb_dcache
  import dcache_cfg_pkg::*;
  import dcache_bus_pkg::*;
();

  localparam int          NUM_REQS       = 400;
  localparam int          MAX_GAP        = 3;
  localparam int          TIMEOUT_CYCLES = NUM_REQS * 25 + 100;
  localparam logic [31:0] SEED           = 32'hbeab_ddf0;

  logic        clk;
  logic        rst;
  logic        cpu_req_valid;
  cpu_req_t    cpu_req;
  logic        cpu_ack;
  cpu_rsp_t    cpu_rsp;
  logic        refill_req_valid;
  refill_req_t refill_req;
  logic        mem_valid;
  mem_word_t   mem_word;
  int          mismatch_cnt;
  int          fault_cnt;
  int          cycle_cnt = 0;
  logic [31:0] lfsr_q;
  // Memory image indexed by tag low bits, set and word
  word_t       mem_img [512];

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  dcache_top i_dut (
    .clk                (clk),
    .rst                (rst),
    .cpu_req_valid_i    (cpu_req_valid),
    .cpu_req_i          (cpu_req),
    .cpu_ack_o          (cpu_ack),
    .cpu_rsp_o          (cpu_rsp),
    .refill_req_valid_o (refill_req_valid),
    .refill_req_o       (refill_req),
    .mem_valid_i        (mem_valid),
    .mem_i              (mem_word)
  );

  dcache_checker i_checker (
    .clk                (clk),
    .rst                (rst),
    .cpu_req_valid_i    (cpu_req_valid),
    .cpu_req_i          (cpu_req),
    .cpu_ack_i          (cpu_ack),
    .cpu_rsp_i          (cpu_rsp),
    .refill_req_valid_i (refill_req_valid),
    .refill_req_i       (refill_req),
    .mem_valid_i        (mem_valid),
    .mismatch_cnt_o     (mismatch_cnt),
    .fault_cnt_o        (fault_cnt)
  );

  //////////////////////////////
  // Random source
  //////////////////////////////

  // Taps 32, 22, 2, 1
  function automatic logic lfsr_bit();
    logic fb;
    fb     = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
    lfsr_q = {lfsr_q[30:0], fb};
    return fb;
  endfunction

  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      v = {v[30:0], lfsr_bit()};
    end
    return v;
  endfunction

  // Low three tag bits are all different
  function automatic tag_t tag_for(input logic [2:0] sel);
    case (sel)
      3'd0:    return 24'h00_0000;
      3'd1:    return 24'h13_a5c1;
      3'd2:    return 24'h7e_0042;
      3'd3:    return 24'h00_ff03;
      3'd4:    return 24'hbe_ef04;
      3'd5:    return 24'h5a_5a05;
      3'd6:    return 24'hc0_0006;
      default: return 24'hde_ad07;
    endcase
  endfunction

  //////////////////////////////
  // CPU side
  //////////////////////////////

  task automatic send_request();
    cpu_req_t   r;
    int         pick;
    logic [2:0] tsel;
    set_idx_t   s;
    word_sel_t  ws;
    pick = rand_bits(8) % 10;
    tsel = 3'(rand_bits(3));
    s    = set_idx_t'(rand_bits(SET_W));
    ws   = word_sel_t'(rand_bits(WORD_SEL_W));
    if (pick < 5) begin
      r.op = OP_READ;
    end else if (pick < 9) begin
      r.op = OP_WRITE;
    end else begin
      r.op = OP_INVAL;
    end
    r.addr  = {tag_for(tsel), s, ws, 2'b00};
    r.bsel  = bsel_t'(rand_bits(4));
    r.wdata = rand_bits(32);
    // Write-through path lands in the image right away
    if (r.op == OP_WRITE) begin
      for (int b = 0; b < 4; b++) begin
        if (r.bsel[b]) begin
          mem_img[r.addr[10:2]][8*b +: 8] = r.wdata[8*b +: 8];
        end
      end
    end
    @(posedge clk);
    #1;
    cpu_req       = r;
    cpu_req_valid = 1'b1;
    @(posedge clk);
    #1;
    cpu_req_valid = 1'b0;
  endtask

  task automatic wait_for_ack();
    @(negedge clk);
    while (cpu_ack !== 1'b1) begin
      @(negedge clk);
    end
  endtask

  //////////////////////////////
  // Memory model
  //////////////////////////////

  // Four words in order with random idle gaps between them
  task automatic return_block(input addr_t base);
    int gap;
    for (int w = 0; w < WORDS_PER_BLOCK; w++) begin
      gap = rand_bits(2) % (MAX_GAP + 1);
      repeat (gap) begin
        @(posedge clk);
        #1;
        mem_valid = 1'b0;
      end
      @(posedge clk);
      #1;
      mem_valid = 1'b1;
      mem_word  = mem_img[{base[10:4], w[1:0]}];
    end
    @(posedge clk);
    #1;
    mem_valid = 1'b0;
  endtask

  initial begin
    mem_valid = 1'b0;
    mem_word  = '0;
    forever begin
      @(negedge clk);
      if (!rst && refill_req_valid) begin
        return_block(refill_req.block_addr);
      end
    end
  end

  always @(posedge clk) begin
    cycle_cnt++;
    if (cycle_cnt > TIMEOUT_CYCLES) begin
      $display("Timeout after %0d cycles, the DUT stopped acknowledging", cycle_cnt);
      $display("Errors: %0d mismatches, %0d other failures", mismatch_cnt, fault_cnt);
      $display("Something failed");
      $finish;
    end
  end

  initial begin
    lfsr_q        = SEED;
    rst           = 1'b1;
    cpu_req_valid = 1'b0;
    cpu_req       = '0;
    for (int i = 0; i < 512; i++) begin
      mem_img[i] = (i * 32'h9e37_79b9) ^ 32'ha5c3_0f96;
    end
    repeat (10) @(posedge clk);
    #1;
    rst = 1'b0;
    for (int n = 0; n < NUM_REQS; n++) begin
      send_request();
      wait_for_ack();
    end
    // Idle tail where nothing may answer
    repeat (5) @(posedge clk);
    $display("Errors: %0d mismatches, %0d other failures", mismatch_cnt, fault_cnt);
    if (mismatch_cnt == 0 && fault_cnt == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

endmodule
